// ==== Bender.yml ====
package:
  name: multicycleControl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/controlPkg.sv
      - rtl/opcodeClassifier.sv
      - rtl/mainStateMachine.sv
      - rtl/controlSignalDecoder.sv
      - rtl/multicycleControl.sv
  - target: test
    files:
      - bench/controlChecker.sv
      - bench/multicycleControlTb.sv

// ==== bench/controlChecker.sv ====
`timescale 1ns/1ps

module controlChecker
    import controlPkg::*;
(
    input  logic       clk,
    input  logic       rstN,
    input  logic [6:0] opcode,
    input  int         expectedCycles,
    input  ctrlState_e currentState,
    input  logic       pcWrite,
    input  logic       pcWriteCond,
    input  logic       iorD,
    input  logic       memRead,
    input  logic       memWrite,
    input  logic       irWrite,
    input  logic       memToReg,
    input  logic       pcSource1,
    input  logic       pcSource0,
    input  logic       aluOp1,
    input  logic       aluOp0,
    input  logic       aluSrcB1,
    input  logic       aluSrcB0,
    input  logic       aluSrcA,
    input  logic       regWrite,
    input  logic       regDst,
    output int         valueErrors,
    output int         lengthErrors
);

    logic [3:0]  modelState;
    logic        modelValid;
    int          pathCount;
    int          pathExpected;
    logic [6:0]  pathOpcode;
    logic [15:0] observed;

    // Bit i is output i of the truth table, pcWrite first
    assign observed = {regDst, regWrite, aluSrcA, aluSrcB0, aluSrcB1, aluOp0, aluOp1,
                       pcSource0, pcSource1, memToReg, irWrite, memWrite, memRead,
                       iorD, pcWriteCond, pcWrite};

    initial begin
        modelState   = 4'd0;
        modelValid   = 1'b0;
        pathCount    = 0;
        pathExpected = 0;
        pathOpcode   = 7'h00;
        valueErrors  = 0;
        lengthErrors = 0;
    end

    // Set of states in which each output is high, one bit per state code
    function automatic logic [15:0] activeStates(input int idx);
        case (idx)
            0:       activeStates = 16'h1401;
            1:       activeStates = 16'h0100;
            2:       activeStates = 16'h0028;
            3:       activeStates = 16'h1A09;
            4:       activeStates = 16'h0020;
            5:       activeStates = 16'h0001;
            6:       activeStates = 16'h0010;
            7:       activeStates = 16'h0200;
            8:       activeStates = 16'h0100;
            9:       activeStates = 16'h2040;
            10:      activeStates = 16'h0100;
            11:      activeStates = 16'h3C06;
            12:      activeStates = 16'h0203;
            13:      activeStates = 16'h3144;
            14:      activeStates = 16'h0290;
            default: activeStates = 16'h0080;
        endcase
    endfunction

    function automatic string outputName(input int idx);
        string names [16];
        names = '{"pcWrite", "pcWriteCond", "iorD", "memRead", "memWrite", "irWrite",
                  "memToReg", "pcSource1", "pcSource0", "aluOp1", "aluOp0", "aluSrcB1",
                  "aluSrcB0", "aluSrcA", "regWrite", "regDst"};
        outputName = names[idx];
    endfunction

    // Reference next-state rule, keyed on raw opcodes
    function automatic logic [3:0] predictNext(input logic [3:0] cur, input logic [6:0] op);
        predictNext = stFetch;
        case (cur)
            stFetch: predictNext = stDecode;
            stDecode: begin
                case (op)
                    7'h03, 7'h23: predictNext = stMemAddr;
                    7'h33:        predictNext = stExecR;
                    7'h13:        predictNext = stExecI;
                    7'h63:        predictNext = stBranch;
                    7'h6F, 7'h67: predictNext = stLinkSave;
                    7'h17:        predictNext = stAuipc;
                    default:      predictNext = stFetch;
                endcase
            end
            stMemAddr:        predictNext = (op == 7'h03) ? stMemRead : stMemWrite;
            stMemRead:        predictNext = stLoadWb;
            stExecR, stExecI: predictNext = stAluWb;
            stLinkSave:       predictNext = (op == 7'h67) ? stJalrJump : stJalJump;
            default:          predictNext = stFetch;
        endcase
    endfunction

    always @(posedge clk) begin : compareBlock
        logic [15:0] mask;
        int i;
        if (modelValid) begin
            if (currentState !== modelState) begin
                $display("Fail currentState expected %h actual %h at %0t",
                         modelState, currentState, $time);
                valueErrors++;
            end
            for (i = 0; i < 16; i++) begin
                mask = activeStates(i);
                if (observed[i] !== mask[modelState]) begin
                    $display("Fail %s expected %h actual %h in state %h at %0t",
                             outputName(i), mask[modelState], observed[i], modelState, $time);
                    valueErrors++;
                end
            end
        end
        if (!rstN) begin
            // Reset cuts any path short, so no length check for it
            modelState <= stFetch;
            modelValid <= 1'b1;
            pathCount  <= 0;
        end else if (modelValid) begin
            // Path length is taken from the DUT state
            if (currentState == stFetch) begin
                if (pathCount != 0 && pathCount != pathExpected) begin
                    $display("Instruction with opcode %h took %0d cycles instead of %0d",
                             pathOpcode, pathCount, pathExpected);
                    lengthErrors++;
                end
                pathCount    <= 1;
                pathExpected <= expectedCycles;
                pathOpcode   <= opcode;
            end else if (pathCount != 0) begin
                pathCount <= pathCount + 1;
            end
            modelState <= predictNext(modelState, opcode);
        end
    end

endmodule

// ==== bench/multicycleControlTb.sv ====
`timescale 1ns/1ps

module multicycleControlTb
    import controlPkg::*;
();

    localparam int RANDOM_ROWS   = 40;
    localparam int MARGIN_CYCLES = 50;

    logic       clk;
    logic       rstN;
    logic [6:0] opcode;
    int         expectedCycles;
    ctrlState_e currentState;
    logic       pcWrite, pcWriteCond, iorD, memRead, memWrite, irWrite, memToReg;
    logic       pcSource1, pcSource0, aluOp1, aluOp0, aluSrcB1, aluSrcB0, aluSrcA;
    logic       regWrite, regDst;
    int         valueErrors;
    int         lengthErrors;
    int         cycleCount;
    int         cycleLimit;

    // Stimulus table: opcode, path length, cycles before a reset pulse (0 for none)
    logic [6:0] rowOpcode [$];
    int         rowCycles [$];
    int         rowResetAt [$];
    // Random pool, the eight supported opcodes and some illegal ones
    logic [6:0] poolOpcode [12] = '{7'h03, 7'h23, 7'h33, 7'h13, 7'h63, 7'h6F,
                                    7'h67, 7'h17, 7'h00, 7'h37, 7'h0F, 7'h7F};
    int         poolCycles [12] = '{5, 4, 4, 4, 3, 4, 4, 3, 2, 2, 2, 2};

    multicycleControl multicycleControl_inst (
        .clk(clk), .rstN(rstN), .opcode(opcode), .currentState(currentState),
        .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .iorD(iorD), .memRead(memRead),
        .memWrite(memWrite), .irWrite(irWrite), .memToReg(memToReg),
        .pcSource1(pcSource1), .pcSource0(pcSource0), .aluOp1(aluOp1), .aluOp0(aluOp0),
        .aluSrcB1(aluSrcB1), .aluSrcB0(aluSrcB0), .aluSrcA(aluSrcA),
        .regWrite(regWrite), .regDst(regDst)
    );

    controlChecker controlChecker_inst (
        .clk(clk), .rstN(rstN), .opcode(opcode), .expectedCycles(expectedCycles),
        .currentState(currentState),
        .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .iorD(iorD), .memRead(memRead),
        .memWrite(memWrite), .irWrite(irWrite), .memToReg(memToReg),
        .pcSource1(pcSource1), .pcSource0(pcSource0), .aluOp1(aluOp1), .aluOp0(aluOp0),
        .aluSrcB1(aluSrcB1), .aluSrcB0(aluSrcB0), .aluSrcA(aluSrcA),
        .regWrite(regWrite), .regDst(regDst),
        .valueErrors(valueErrors), .lengthErrors(lengthErrors)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic addRow(input logic [6:0] op, input int cycles, input int resetAt);
        rowOpcode.push_back(op);
        rowCycles.push_back(cycles);
        rowResetAt.push_back(resetAt);
    endtask

    // Hold one opcode until the FSM is back in fetch, or pulse reset mid path
    task automatic runRow(input logic [6:0] op, input int cycles, input int resetAt);
        opcode         = op;
        expectedCycles = cycles;
        if (resetAt > 0) begin
            repeat (resetAt) @(negedge clk);
            rstN = 1'b0;
            @(negedge clk);
            rstN = 1'b1;
        end else begin
            @(negedge clk);
            while (currentState != stFetch) begin
                @(negedge clk);
            end
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the instruction sequence did not finish",
                     cycleCount);
            $display("Errors: %0d value, %0d path length, 1 timeout", valueErrors, lengthErrors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    initial begin : mainSequence
        int unsigned seedInit;
        int          idx;
        int          pick;
        int          tableCycles;
        seedInit       = $urandom(61364);
        cycleCount     = 0;
        rstN           = 1'b0;
        opcode         = 7'h00;
        expectedCycles = 0;
        addRow(7'h03, 5, 0);
        addRow(7'h23, 4, 0);
        addRow(7'h33, 4, 0);
        addRow(7'h13, 4, 0);
        addRow(7'h63, 3, 0);
        addRow(7'h6F, 4, 0);
        addRow(7'h67, 4, 0);
        addRow(7'h17, 3, 0);
        addRow(7'h00, 2, 0);
        addRow(7'h7F, 2, 0);
        // Reset inside a load and inside a jalr, then the same instruction again
        addRow(7'h03, 5, 3);
        addRow(7'h03, 5, 0);
        addRow(7'h67, 4, 2);
        addRow(7'h67, 4, 0);
        addRow(7'h23, 4, 0);
        tableCycles = 0;
        foreach (rowCycles[i]) begin
            tableCycles += rowCycles[i];
        end
        cycleLimit = tableCycles + RANDOM_ROWS * 5 + MARGIN_CYCLES;
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        for (idx = 0; idx < rowOpcode.size(); idx++) begin
            runRow(rowOpcode[idx], rowCycles[idx], rowResetAt[idx]);
        end
        for (idx = 0; idx < RANDOM_ROWS; idx++) begin
            pick = $urandom % 12;
            runRow(poolOpcode[pick], poolCycles[pick], 0);
        end
        // One more edge so the checker closes the last path
        @(negedge clk);
        $display("Errors: %0d value, %0d path length, 0 timeout", valueErrors, lengthErrors);
        if (valueErrors + lengthErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== multicycleControl.f ====
+incdir+rtl
rtl/controlPkg.sv
rtl/opcodeClassifier.sv
rtl/mainStateMachine.sv
rtl/controlSignalDecoder.sv
rtl/multicycleControl.sv
bench/controlChecker.sv
bench/multicycleControlTb.sv

// ==== rtl/controlParams_params.svh ====
`ifndef CONTROL_PARAMS_SVH
`define CONTROL_PARAMS_SVH

// Width of the control state register
// Holds the fourteen used state codes plus two spare ones
`define CTRL_STATE_W 4

// Width of the major opcode field of the instruction word
// Bits [6:0] in the RISC-V base encoding
`define CTRL_OPCODE_W 7

`endif

// ==== rtl/controlPkg.sv ====
`include "controlParams_params.svh"

package controlPkg;

    // Control states, one cycle each
    typedef enum logic [`CTRL_STATE_W-1:0] {
        stFetch    = 4'd0,
        stDecode   = 4'd1,
        stMemAddr  = 4'd2,
        stMemRead  = 4'd3,
        stLoadWb   = 4'd4,
        stMemWrite = 4'd5,
        stExecR    = 4'd6,
        stAluWb    = 4'd7,
        stBranch   = 4'd8,
        // PC+4 into rd, shared by jal and jalr
        stLinkSave = 4'd9,
        stJalJump  = 4'd10,
        stAuipc    = 4'd11,
        stJalrJump = 4'd12,
        stExecI    = 4'd13
    } ctrlState_e;

    // Base opcodes recognised by the classifier
    typedef enum logic [`CTRL_OPCODE_W-1:0] {
        opLoad   = 7'h03,
        opIType  = 7'h13,
        opAuipc  = 7'h17,
        opStore  = 7'h23,
        opRType  = 7'h33,
        opBranch = 7'h63,
        opJalr   = 7'h67,
        opJal    = 7'h6F
    } baseOpcode_e;

    // Instruction classes seen by the state machine
    typedef enum logic [3:0] {
        icLoad,
        icStore,
        icRType,
        icIType,
        icBranch,
        icJal,
        icJalr,
        icAuipc,
        icIllegal
    } instrClass_e;

endpackage

// ==== rtl/controlSignalDecoder.sv ====
`timescale 1ns/1ps
`include "controlParams_params.svh"

module controlSignalDecoder
    import controlPkg::*;
(
    input  ctrlState_e state,
    output logic       pcWrite,
    output logic       pcWriteCond,
    output logic       iorD,
    output logic       memRead,
    output logic       memWrite,
    output logic       irWrite,
    output logic       memToReg,
    output logic       pcSource1,
    output logic       pcSource0,
    output logic       aluOp1,
    output logic       aluOp0,
    output logic       aluSrcB1,
    output logic       aluSrcB0,
    output logic       aluSrcA,
    output logic       regWrite,
    output logic       regDst
);

    // One line per state code, bits 14 and 15 feed no output
    logic [(1 << `CTRL_STATE_W)-1:0] stateHot;

    assign stateHot = {{((1 << `CTRL_STATE_W) - 1){1'b0}}, 1'b1} << state;

    // Next PC select
    assign pcWrite     = stateHot[stFetch] | stateHot[stJalJump] | stateHot[stJalrJump];
    assign pcWriteCond = stateHot[stBranch];
    assign pcSource1   = stateHot[stLinkSave];
    assign pcSource0   = stateHot[stBranch];

    // Memory side, iorD picks the ALU result as address
    assign iorD     = stateHot[stMemRead] | stateHot[stMemWrite];
    assign memRead  = stateHot[stFetch]
                    | stateHot[stMemRead]
                    | stateHot[stLinkSave]
                    | stateHot[stAuipc]
                    | stateHot[stJalrJump];
    assign memWrite = stateHot[stMemWrite];
    assign irWrite  = stateHot[stFetch];

    // ALU operation class
    assign aluOp1 = stateHot[stExecR] | stateHot[stExecI];
    assign aluOp0 = stateHot[stBranch];

    // B operand: 01 is constant 4, 10 is the immediate
    assign aluSrcB1 = stateHot[stDecode]
                    | stateHot[stMemAddr]
                    | stateHot[stJalJump]
                    | stateHot[stAuipc]
                    | stateHot[stJalrJump]
                    | stateHot[stExecI];
    assign aluSrcB0 = stateHot[stFetch] | stateHot[stDecode] | stateHot[stLinkSave];

    // A operand is rs1 rather than PC
    assign aluSrcA = stateHot[stMemAddr]
                   | stateHot[stExecR]
                   | stateHot[stBranch]
                   | stateHot[stJalrJump]
                   | stateHot[stExecI];

    // Register file write back
    assign memToReg = stateHot[stLoadWb];
    assign regWrite = stateHot[stLoadWb] | stateHot[stAluWb] | stateHot[stLinkSave];
    assign regDst   = stateHot[stAluWb];

endmodule

// ==== rtl/mainStateMachine.sv ====
`timescale 1ns/1ps
`include "controlParams_params.svh"

module mainStateMachine
    import controlPkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instrClass_e instrClass,
    output ctrlState_e  state
);

    // Raw register, so codes 14 and 15 can still be decoded and left
    logic [`CTRL_STATE_W-1:0] stateQ;
    ctrlState_e               nextState;

    assign state = ctrlState_e'(stateQ);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stateQ <= stFetch;
        end else begin
            stateQ <= nextState;
        end
    end

    always_comb begin
        nextState = stFetch;
        case (state)
            stFetch: begin
                nextState = stDecode;
            end

            // Dispatch on instruction class
            stDecode: begin
                case (instrClass)
                    icLoad, icStore: begin
                        nextState = stMemAddr;
                    end
                    icRType: begin
                        nextState = stExecR;
                    end
                    icIType: begin
                        nextState = stExecI;
                    end
                    icBranch: begin
                        nextState = stBranch;
                    end
                    icJal, icJalr: begin
                        nextState = stLinkSave;
                    end
                    icAuipc: begin
                        nextState = stAuipc;
                    end
                    default: begin
                        nextState = stFetch;
                    end
                endcase
            end

            // Load or store split after address compute
            stMemAddr: begin
                if (instrClass == icLoad) begin
                    nextState = stMemRead;
                end else begin
                    nextState = stMemWrite;
                end
            end

            stMemRead: begin
                nextState = stLoadWb;
            end

            stExecR, stExecI: begin
                nextState = stAluWb;
            end

            // Link is saved first, then the jump target differs
            stLinkSave: begin
                if (instrClass == icJalr) begin
                    nextState = stJalrJump;
                end else begin
                    nextState = stJalJump;
                end
            end

            // Last state of every path, also catches spare codes
            default: begin
                nextState = stFetch;
            end
        endcase
    end

endmodule

// ==== rtl/multicycleControl.sv ====
`timescale 1ns/1ps
`include "controlParams_params.svh"

module multicycleControl
    import controlPkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    output ctrlState_e                currentState,
    output logic                      pcWrite,
    output logic                      pcWriteCond,
    output logic                      iorD,
    output logic                      memRead,
    output logic                      memWrite,
    output logic                      irWrite,
    output logic                      memToReg,
    output logic                      pcSource1,
    output logic                      pcSource0,
    output logic                      aluOp1,
    output logic                      aluOp0,
    output logic                      aluSrcB1,
    output logic                      aluSrcB0,
    output logic                      aluSrcA,
    output logic                      regWrite,
    output logic                      regDst
);

    instrClass_e instrClass;

    opcodeClassifier opcodeClassifier_inst (
        .opcode     (opcode),
        .instrClass (instrClass)
    );

    mainStateMachine mainStateMachine_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrClass (instrClass),
        .state      (currentState)
    );

    // Strobes follow the state within the same cycle
    controlSignalDecoder controlSignalDecoder_inst (
        .state       (currentState),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .iorD        (iorD),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .irWrite     (irWrite),
        .memToReg    (memToReg),
        .pcSource1   (pcSource1),
        .pcSource0   (pcSource0),
        .aluOp1      (aluOp1),
        .aluOp0      (aluOp0),
        .aluSrcB1    (aluSrcB1),
        .aluSrcB0    (aluSrcB0),
        .aluSrcA     (aluSrcA),
        .regWrite    (regWrite),
        .regDst      (regDst)
    );

endmodule

// ==== rtl/opcodeClassifier.sv ====
`timescale 1ns/1ps
`include "controlParams_params.svh"

module opcodeClassifier
    import controlPkg::*;
(
    input  logic [`CTRL_OPCODE_W-1:0] opcode,
    output instrClass_e               instrClass
);

    // All encoding knowledge lives here, the FSM only sees classes
    always_comb begin
        case (opcode)
            opLoad: begin
                instrClass = icLoad;
            end
            opStore: begin
                instrClass = icStore;
            end
            opRType: begin
                instrClass = icRType;
            end
            opIType: begin
                instrClass = icIType;
            end
            opBranch: begin
                instrClass = icBranch;
            end
            opJal: begin
                instrClass = icJal;
            end
            opJalr: begin
                instrClass = icJalr;
            end
            opAuipc: begin
                instrClass = icAuipc;
            end
            // Anything else is unsupported and goes back to fetch
            default: begin
                instrClass = icIllegal;
            end
        endcase
    end

endmodule
